/* common/awg_pkg.sv */
package awg_pkg;

	// apb bus widths
	localparam int APB_ADDR_W = 12;
	localparam int APB_DATA_W = 32;

	// fraction bits carried on the interpolated output
	localparam int FRAC_BITS = 4;

	// one stored sample, two's complement
	typedef logic signed [7:0] sample_t;

	// interpolated output, 8 integer bits over 4 fraction bits
	typedef logic signed [11:0] interp_t;

	// log2 of the upsampling ratio
	typedef logic [2:0] ratio_t;

	// legal ratio range, 2x up to 16x
	localparam ratio_t RATIO_MIN = 3'd1;
	localparam ratio_t RATIO_MAX = 3'd4;

	// register map
	localparam logic [APB_ADDR_W-1:0] CTRL_ADDR   = 12'h000;
	localparam logic [APB_ADDR_W-1:0] STATUS_ADDR = 12'h004;
	localparam logic [APB_ADDR_W-1:0] SAMPLE_BASE = 12'h100;

	// one apb write word, read as control fields or as four samples
	typedef union packed {
		struct packed {
			logic [15:0] reserved_hi;
			// index of the last sample played
			logic [7:0]  length;
			logic [3:0]  reserved_lo;
			ratio_t      ratio_log2;
			logic        enable;
		} ctrl;
		// lowest address sits in the lowest byte
		sample_t [3:0] samples;
	} apb_word_u;

endpackage

/* logic/awg_regs.sv */
`timescale 1ns/1ps

module awg_regs
	import awg_pkg::*;
#(
	parameter int SAMPLE_DEPTH = 64
) (
	input  logic                            clock,
	input  logic                            reset,

	// apb slave
	input  logic [APB_ADDR_W-1:0]           paddr,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [APB_DATA_W-1:0]           pwdata,
	output logic [APB_DATA_W-1:0]           prdata,
	output logic                            pready,
	output logic                            pslverr,

	// sample store write port
	output logic                            wr_en,
	output logic [$clog2(SAMPLE_DEPTH/4)-1:0] wr_index,
	output sample_t [3:0]                   wr_data,

	// playback side
	output logic [$clog2(SAMPLE_DEPTH)-1:0] rd_addr,
	output logic                            sample_tick,
	output ratio_t                          ratio_log2
);

	localparam int ADDR_W = $clog2(SAMPLE_DEPTH);
	// first byte address past the sample window
	localparam logic [APB_ADDR_W-1:0] WINDOW_END = SAMPLE_BASE + APB_ADDR_W'(SAMPLE_DEPTH);

	apb_word_u         wr_word;
	apb_word_u         rd_word;

	logic              access;
	logic              aligned;
	logic              is_ctrl;
	logic              is_status;
	logic              in_window;
	logic              addr_ok;
	logic              ctrl_wr;
	logic              start;

	// control register
	logic              enable_r;
	ratio_t            ratio_r;
	logic [ADDR_W-1:0] last_addr;

	// sample period sequencer
	logic [3:0]        phase;
	logic [4:0]        period;
	logic              last_phase;
	logic              load;

	// incoming write word, decoded per address below
	assign wr_word = pwdata;

	// access phase of a transfer
	assign access    = psel && penable;
	assign aligned   = (paddr[1:0] == 2'b00);
	assign is_ctrl   = (paddr == CTRL_ADDR);
	assign is_status = (paddr == STATUS_ADDR);
	assign in_window = (paddr >= SAMPLE_BASE) && (paddr < WINDOW_END);
	assign addr_ok   = aligned && (is_ctrl || is_status || in_window);

	// no wait states
	assign pready  = 1'b1;
	// bad or unaligned address, the transfer is dropped
	assign pslverr = access && !addr_ok;

	assign ctrl_wr = access && pwrite && is_ctrl;
	// enable going from off to on restarts playback at address 0
	assign start   = ctrl_wr && wr_word.ctrl.enable && !enable_r;

	// sample writes go through the four-sample view
	assign wr_en    = access && pwrite && in_window && aligned;
	// window base is a multiple of the window size, so low bits give the word
	assign wr_index = paddr[ADDR_W-1:2];
	assign wr_data  = wr_word.samples;

	always_ff @(posedge clock) begin
		if (reset) begin
			enable_r  <= 1'b0;
			ratio_r   <= RATIO_MIN;
			last_addr <= '0;
		end else if (ctrl_wr) begin
			enable_r  <= wr_word.ctrl.enable;
			ratio_r   <= wr_word.ctrl.ratio_log2;
			last_addr <= wr_word.ctrl.length[ADDR_W-1:0];
		end
	end

	assign ratio_log2 = ratio_r;

	// clocks per sample period
	assign period     = 5'd1 << ratio_r;
	// >= keeps the counter bounded if the ratio shrinks mid period
	assign last_phase = ({1'b0, phase} >= (period - 5'd1));

	always_ff @(posedge clock) begin
		if (reset) begin
			phase       <= '0;
			load        <= 1'b0;
			sample_tick <= 1'b0;
			rd_addr     <= '0;
		end else begin
			// tick trails load by one cycle to match the store read latency
			sample_tick <= load;
			if (start) begin
				phase   <= '0;
				load    <= 1'b0;
				rd_addr <= '0;
			end else if (enable_r) begin
				load  <= last_phase;
				phase <= last_phase ? 4'd0 : phase + 4'd1;
				// step to the next sample, wrap after the last one
				if (load) begin
					if (rd_addr >= last_addr) begin
						rd_addr <= '0;
					end else begin
						rd_addr <= rd_addr + 1'b1;
					end
				end
			end else begin
				phase <= '0;
				load  <= 1'b0;
			end
		end
	end

	// read mux, ctrl fields come back through the same union
	always_comb begin
		rd_word = '0;
		if (is_ctrl) begin
			rd_word.ctrl.enable     = enable_r;
			rd_word.ctrl.ratio_log2 = ratio_r;
			rd_word.ctrl.length     = 8'(last_addr);
		end else if (is_status) begin
			// current play address
			rd_word = APB_DATA_W'(rd_addr);
		end
		prdata = rd_word;
	end

	// host must raise psel in the setup cycle before penable
	assert property (@(posedge clock) disable iff (reset)
		penable |-> psel);

	// a ctrl write leaves a legal ratio behind
	assert property (@(posedge clock) disable iff (reset)
		(ctrl_wr && !pslverr) |=> (ratio_r >= RATIO_MIN && ratio_r <= RATIO_MAX));

endmodule

/* logic/sample_store.sv */
`timescale 1ns/1ps

module sample_store
	import awg_pkg::*;
#(
	parameter int SAMPLE_DEPTH = 64
) (
	input  logic                              clock,

	// word write of four samples at once
	input  logic                              wr_en,
	input  logic [$clog2(SAMPLE_DEPTH/4)-1:0] wr_index,
	input  sample_t [3:0]                     wr_data,

	// single sample read with one cycle latency
	input  logic [$clog2(SAMPLE_DEPTH)-1:0]   rd_addr,
	output sample_t                           rd_sample
);

	localparam int ADDR_W = $clog2(SAMPLE_DEPTH);
	localparam int WORDS  = SAMPLE_DEPTH / 4;

	// one bank per byte lane
	sample_t lane_mem [4][WORDS];

	logic [1:0]        rd_lane;
	logic [ADDR_W-3:0] rd_word;

	// low address bits pick the lane and the rest pick the word
	assign rd_lane = rd_addr[1:0];
	assign rd_word = rd_addr[ADDR_W-1:2];

	// every lane takes its byte of the write word
	always_ff @(posedge clock) begin
		if (wr_en) begin
			for (int lane = 0; lane < 4; lane++) begin
				lane_mem[lane][wr_index] <= wr_data[lane];
			end
		end
	end

	// registered read
	always_ff @(posedge clock) begin
		rd_sample <= lane_mem[rd_lane][rd_word];
	end

endmodule

/* interp/interp.sv */
`timescale 1ns/1ps

module interp
	import awg_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  sample_t rd_sample,
	input  logic    sample_tick,
	input  ratio_t  ratio_log2,
	output interp_t out_sample
);

	// last two samples taken from the store
	sample_t            prev;
	sample_t            curr;

	// ramp accumulator, in fraction units
	interp_t            acc;
	interp_t            target;

	logic signed [8:0]  diff;
	logic [2:0]         shift;
	logic signed [12:0] step;
	logic signed [12:0] sum;

	// ramp end point, current sample scaled to fraction units
	assign target = {curr, {FRAC_BITS{1'b0}}};

	// slope over one sample period, needs a ninth bit
	assign diff = {curr[7], curr} - {prev[7], prev};

	// step per clock is diff * 16 / 2^ratio, so a plain left shift
	assign shift = 3'(FRAC_BITS) - ratio_log2;
	assign step  = {{4{diff[8]}}, diff} << shift;

	// one bit of headroom for the add
	assign sum = {acc[11], acc} + step;

	always_ff @(posedge clock) begin
		if (reset) begin
			prev <= '0;
			curr <= '0;
			acc  <= '0;
		end else if (sample_tick) begin
			// new sample, ramp restarts from the old current value
			prev <= curr;
			curr <= rd_sample;
			acc  <= target;
		end else if (acc != target) begin
			// steps are exact, so the ramp lands on target and holds there
			acc <= sum[11:0];
		end
	end

	assign out_sample = acc;

	// ratio must be stable when a ramp starts
	assert property (@(posedge clock) disable iff (reset)
		sample_tick |-> $stable(ratio_log2));

endmodule

/* logic/awg_top.sv */
`timescale 1ns/1ps

module awg_top
	import awg_pkg::*;
#(
	parameter int SAMPLE_DEPTH = 64
) (
	input  logic                  clock,
	input  logic                  reset,

	// apb slave
	input  logic [APB_ADDR_W-1:0] paddr,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [APB_DATA_W-1:0] pwdata,
	output logic [APB_DATA_W-1:0] prdata,
	output logic                  pready,
	output logic                  pslverr,

	// waveform out
	output interp_t               out_sample,
	output logic                  tick
);

	// store write port
	logic                              wr_en;
	logic [$clog2(SAMPLE_DEPTH/4)-1:0] wr_index;
	sample_t [3:0]                     wr_data;

	// playback path
	logic [$clog2(SAMPLE_DEPTH)-1:0]   rd_addr;
	sample_t                           rd_sample;
	logic                              sample_tick;
	ratio_t                            ratio_log2;

	awg_regs #(
		.SAMPLE_DEPTH (SAMPLE_DEPTH)
	) u_regs (
		.clock       (clock),
		.reset       (reset),
		.paddr       (paddr),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.wr_en       (wr_en),
		.wr_index    (wr_index),
		.wr_data     (wr_data),
		.rd_addr     (rd_addr),
		.sample_tick (sample_tick),
		.ratio_log2  (ratio_log2)
	);

	sample_store #(
		.SAMPLE_DEPTH (SAMPLE_DEPTH)
	) u_store (
		.clock     (clock),
		.wr_en     (wr_en),
		.wr_index  (wr_index),
		.wr_data   (wr_data),
		.rd_addr   (rd_addr),
		.rd_sample (rd_sample)
	);

	interp u_interp (
		.clock       (clock),
		.reset       (reset),
		.rd_sample   (rd_sample),
		.sample_tick (sample_tick),
		.ratio_log2  (ratio_log2),
		.out_sample  (out_sample)
	);

	// tick marks the first cycle of each ramp
	assign tick = sample_tick;

endmodule

/* bench/awg_checker.sv */
`timescale 1ns/1ps

module awg_checker
	import awg_pkg::*;
#(
	parameter int SAMPLE_DEPTH = 64
) (
	input logic                  clock,
	input logic                  reset,
	input logic [APB_ADDR_W-1:0] paddr,
	input logic                  psel,
	input logic                  penable,
	input logic                  pwrite,
	input logic [APB_DATA_W-1:0] pwdata,
	input logic [APB_DATA_W-1:0] prdata,
	input logic                  pready,
	input logic                  pslverr,
	input interp_t               out_sample,
	input logic                  tick
);

	int      value_errors;
	int      tick_errors;
	int      bus_errors;
	int      ticks_seen;

	// copy of the sample memory taken from the bus writes
	sample_t wave_table [SAMPLE_DEPTH];

	// playback model
	int      cycle;
	int      next_tick;
	int      stop_cycle;
	int      play_idx;
	int      offset;
	int      prev_s;
	int      curr_s;
	int      ratio_m;
	int      last_idx;
	logic    enable_m;
	logic    playing;
	logic    stopping;

	// linear ramp from prev to curr over 2^ratio clocks in 1/16 units
	function automatic interp_t ramp_value(input int prev_v, input int curr_v,
		input int ratio, input int step_no);
		int period;
		int value;
		period = 1 << ratio;
		if (step_no >= period) begin
			value = curr_v * 16;
		end else begin
			// exact since the period divides 16
			value = prev_v * 16 + (step_no * (curr_v - prev_v) * 16) / period;
		end
		return interp_t'(value);
	endfunction

	initial begin
		value_errors = 0;
		tick_errors  = 0;
		bus_errors   = 0;
		ticks_seen   = 0;
		for (int i = 0; i < SAMPLE_DEPTH; i++) begin
			wave_table[i] = '0;
		end
	end

	// outputs and bus are stable mid cycle
	always @(negedge clock) begin : compare
		logic      tick_exp;
		logic      access;
		logic      addr_ok;
		logic      err_exp;
		interp_t   out_exp;
		apb_word_u word;
		int        base;
		if (reset) begin
			enable_m   = 1'b0;
			playing    = 1'b0;
			stopping   = 1'b0;
			ratio_m    = 1;
			last_idx   = 0;
			prev_s     = 0;
			curr_s     = 0;
			offset     = 16;
			play_idx   = 0;
			cycle      = 0;
			next_tick  = 0;
			stop_cycle = 0;
		end else begin
			cycle++;
			// loads before the disable edge still give their tick
			if (playing && stopping && next_tick > stop_cycle + 2) begin
				playing = 1'b0;
			end
			tick_exp = playing && (cycle == next_tick);
			if (tick !== tick_exp) begin
				tick_errors++;
				if (tick_exp) begin
					$display("tick missing in cycle %0d", cycle);
				end else begin
					$display("tick came early or with playback off in cycle %0d", cycle);
				end
			end

			out_exp = ramp_value(prev_s, curr_s, ratio_m, offset);
			if (out_sample !== out_exp) begin
				value_errors++;
				$display("MISMATCH out_sample expected %h actual %h in cycle %0d",
					out_exp, out_sample, cycle);
			end

			// a tick starts the ramp toward the next sample in loop order
			if (tick_exp) begin
				ticks_seen++;
				prev_s    = curr_s;
				curr_s    = wave_table[play_idx];
				play_idx  = (play_idx >= last_idx) ? 0 : play_idx + 1;
				offset    = 0;
				next_tick = cycle + (1 << ratio_m);
			end else if (offset < 16) begin
				offset++;
			end

			// no wait states on any transfer
			if (pready !== 1'b1) begin
				bus_errors++;
				$display("MISMATCH pready expected %h actual %h in cycle %0d",
					1'b1, pready, cycle);
			end

			access  = psel && penable;
			addr_ok = (paddr[1:0] == 2'b00) && ((paddr == CTRL_ADDR) ||
				(paddr == STATUS_ADDR) || ((int'(paddr) >= int'(SAMPLE_BASE)) &&
				(int'(paddr) < int'(SAMPLE_BASE) + SAMPLE_DEPTH)));
			err_exp = access && !addr_ok;
			if (pslverr !== err_exp) begin
				bus_errors++;
				$display("MISMATCH pslverr expected %h actual %h at paddr %h",
					err_exp, pslverr, paddr);
			end

			// status returns the address of the next sample to play
			if (access && addr_ok && !pwrite && paddr == STATUS_ADDR) begin
				if (prdata !== APB_DATA_W'(play_idx)) begin
					bus_errors++;
					$display("MISMATCH prdata expected %h actual %h",
						APB_DATA_W'(play_idx), prdata);
				end
			end

			// writes take effect on the edge that ends this cycle
			if (access && addr_ok && pwrite) begin
				word = pwdata;
				if (paddr == CTRL_ADDR) begin
					if (word.ctrl.enable && !enable_m) begin
						playing   = 1'b1;
						stopping  = 1'b0;
						play_idx  = 0;
						next_tick = cycle + (1 << int'(word.ctrl.ratio_log2)) + 2;
					end else if (!word.ctrl.enable && enable_m) begin
						stopping   = 1'b1;
						stop_cycle = cycle;
					end
					enable_m = word.ctrl.enable;
					ratio_m  = int'(word.ctrl.ratio_log2);
					last_idx = int'(word.ctrl.length);
				end else if (paddr >= SAMPLE_BASE) begin
					base = int'(paddr - SAMPLE_BASE);
					for (int lane = 0; lane < 4; lane++) begin
						wave_table[base + lane] = word.samples[lane];
					end
				end
			end
		end
	end

endmodule

/* bench/awg_tb.sv */
`timescale 1ns/1ps

module awg_tb;
	import awg_pkg::*;

	localparam int SAMPLE_DEPTH = 64;
	localparam logic [31:0] RAND_SEED = 32'h3978a5f4;
	// clocks spent in sample periods over all tests
	localparam int PERIOD_CYCLES = 17 * (4 + 2 + 8 + 16) + 9 * 4 + 9 * 4 + 5 * (16 + 2);
	// bus transfers, start delays and settling
	localparam int MAX_CYCLES = PERIOD_CYCLES + 1500;

	logic                  clock;
	logic                  reset;
	logic [APB_ADDR_W-1:0] paddr;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [APB_DATA_W-1:0] pwdata;
	logic [APB_DATA_W-1:0] prdata;
	logic                  pready;
	logic                  pslverr;
	interp_t               out_sample;
	logic                  tick;

	sample_t               wave [SAMPLE_DEPTH];
	int                    ratio_list [3];
	int                    play_ratio;
	int                    play_last;
	int                    cycles;
	int                    total;

	awg_top #(
		.SAMPLE_DEPTH (SAMPLE_DEPTH)
	) UUT (
		.clock      (clock),
		.reset      (reset),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.out_sample (out_sample),
		.tick       (tick)
	);

	awg_checker #(
		.SAMPLE_DEPTH (SAMPLE_DEPTH)
	) chk (
		.clock      (clock),
		.reset      (reset),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.out_sample (out_sample),
		.tick       (tick)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// hard stop if playback never delivers the ticks we wait for
	initial cycles = 0;
	always @(posedge clock) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout, test sequence still running after %0d cycles", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic idle(input int count);
		repeat (count) @(posedge clock);
	endtask

	// setup cycle followed by access cycle
	task automatic transfer(input logic [APB_ADDR_W-1:0] addr, input logic is_write,
		input logic [APB_DATA_W-1:0] data);
		@(posedge clock);
		#1;
		paddr   = addr;
		pwdata  = data;
		pwrite  = is_write;
		psel    = 1'b1;
		penable = 1'b0;
		@(posedge clock);
		#1;
		penable = 1'b1;
		@(posedge clock);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic write_reg(input logic [APB_ADDR_W-1:0] addr, input apb_word_u word);
		transfer(addr, 1'b1, word);
	endtask

	task automatic read_reg(input logic [APB_ADDR_W-1:0] addr);
		transfer(addr, 1'b0, '0);
	endtask

	// four samples per word with the lowest address in the lowest byte
	task automatic load_wave(input int count);
		apb_word_u word;
		for (int i = 0; i < count / 4; i++) begin
			for (int j = 0; j < 4; j++) begin
				word.samples[j] = wave[4 * i + j];
			end
			write_reg(SAMPLE_BASE + APB_ADDR_W'(4 * i), word);
		end
	endtask

	task automatic start_play(input int ratio, input int last);
		apb_word_u word;
		word = '0;
		word.ctrl.enable     = 1'b1;
		word.ctrl.ratio_log2 = ratio_t'(ratio);
		word.ctrl.length     = 8'(last);
		play_ratio = ratio;
		play_last  = last;
		write_reg(CTRL_ADDR, word);
	endtask

	// disable with the same ratio and let the last ramp finish
	task automatic stop_play();
		apb_word_u word;
		word = '0;
		word.ctrl.ratio_log2 = ratio_t'(play_ratio);
		word.ctrl.length     = 8'(play_last);
		write_reg(CTRL_ADDR, word);
		idle(40);
	endtask

	task automatic wait_ticks(input int count);
		int seen;
		seen = 0;
		while (seen < count) begin
			@(negedge clock);
			if (tick) begin
				seen++;
			end
		end
	endtask

	initial begin
		apb_word_u bad;
		reset   = 1'b1;
		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		play_ratio = 1;
		play_last  = 0;
		ratio_list[0] = 1;
		ratio_list[1] = 3;
		ratio_list[2] = 4;
		void'($urandom(RAND_SEED));
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;

		// idle after reset with the output flat at zero
		idle(30);
		read_reg(STATUS_ADDR);

		// eight random samples played for two loops at 4x
		for (int i = 0; i < 8; i++) begin
			wave[i] = sample_t'($urandom);
		end
		load_wave(8);
		start_play(2, 7);
		wait_ticks(17);
		stop_play();

		// other ratios over the same table
		for (int i = 0; i < 3; i++) begin
			start_play(ratio_list[i], 7);
			wait_ticks(17);
			stop_play();
		end

		// four sample loop with status reads
		start_play(2, 3);
		wait_ticks(3);
		read_reg(STATUS_ADDR);
		wait_ticks(6);
		read_reg(STATUS_ADDR);
		stop_play();

		// rejected writes outside the window and unaligned
		bad.samples[0] = 8'sh7f;
		bad.samples[1] = 8'sh7f;
		bad.samples[2] = 8'sh7f;
		bad.samples[3] = 8'sh7f;
		write_reg(12'h200, bad);
		write_reg(12'h102, bad);
		write_reg(12'h008, bad);
		bad = '0;
		bad.ctrl.enable     = 1'b1;
		bad.ctrl.ratio_log2 = 3'd1;
		write_reg(12'h001, bad);
		idle(10);
		start_play(2, 3);
		wait_ticks(9);
		stop_play();

		// full scale steps in both directions
		wave[0] = -8'sd128;
		wave[1] = 8'sd127;
		wave[2] = -8'sd128;
		wave[3] = 8'sd127;
		load_wave(4);
		start_play(4, 1);
		wait_ticks(5);
		stop_play();
		start_play(1, 1);
		wait_ticks(5);
		stop_play();

		idle(5);
		total = chk.value_errors + chk.tick_errors + chk.bus_errors;
		$display("errors: %0d value, %0d tick, %0d bus over %0d ticks", chk.value_errors,
			chk.tick_errors, chk.bus_errors, chk.ticks_seen);
		if (total == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* awg_top.f */
common/awg_pkg.sv
logic/awg_regs.sv
logic/sample_store.sv
interp/interp.sv
logic/awg_top.sv
bench/awg_checker.sv
bench/awg_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	--top-module awg_tb -f awg_top.f -o awg_sim &&
./obj_dir/awg_sim | tee /dev/stderr | grep -qxF "Finished with no errors" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
